//--- Bender.yml
package:
  name: l2_cache

sources:
  - src/l2_pkg.sv
  - src/l2_tag_store.sv
  - src/l2_plru.sv
  - src/l2_data_store.sv
  - src/l2_ctrl.sv
  - src/l2_cache.sv
  - target: test
    files:
      - testbench/l2_checker.sv
      - testbench/tb_l2_cache.sv

//--- src/l2_cache.sv
`timescale 1ns/1ps

module l2_cache (
    input  logic                      clk,
    input  logic                      rstn,
    // instruction side
    input  logic                      i_req,
    input  logic [l2_pkg::ADDR_W-1:0] i_addr,
    output logic                      i_addr_ok,
    output logic                      i_data_ok,
    // data side
    input  logic                      d_req,
    input  logic                      d_we,
    input  logic [l2_pkg::ADDR_W-1:0] d_addr,
    input  logic [l2_pkg::WORD_W-1:0] d_wdata,
    output logic                      d_addr_ok,
    output logic                      d_data_ok,
    output logic [l2_pkg::WORD_W-1:0] rdata,
    // memory port
    output logic                      mem_req_w,
    output logic                      mem_req_r,
    output logic                      mem_rdy,
    output logic [l2_pkg::ADDR_W-1:0] mem_addr,
    output logic [l2_pkg::LINE_W-1:0] mem_wline,
    input  logic                      mem_addr_ok_w,
    input  logic                      mem_addr_ok_r,
    input  logic                      mem_data_ok,
    input  logic [l2_pkg::LINE_W-1:0] mem_rline
);

    logic [l2_pkg::INDEX_W-1:0]  lookup_index;
    logic [l2_pkg::TAG_W-1:0]    lookup_tag;
    logic [l2_pkg::WAYS-1:0]     hit;
    logic [l2_pkg::WAYS-1:0]     touch;
    logic [l2_pkg::WAY_W-1:0]    victim_way;
    logic [l2_pkg::WAY_W-1:0]    update_way;
    logic [l2_pkg::WAY_W-1:0]    victim_d;
    logic [l2_pkg::WAY_W-1:0]    way_sel;
    logic [l2_pkg::TAG_W-1:0]    victim_tag;
    logic [l2_pkg::OFFSET_W-1:0] word_sel;
    logic [l2_pkg::WORD_W-1:0]   wdata_out;
    logic                        victim_dirty, victim_i;
    logic                        fill_en, mark_dirty;
    logic                        line_we, word_we, from_fill;

    l2_ctrl u_ctrl (
        .clk, .rstn,
        .i_req, .i_addr, .i_addr_ok, .i_data_ok,
        .d_req, .d_we, .d_addr, .d_wdata, .d_addr_ok, .d_data_ok,
        .mem_req_w, .mem_req_r, .mem_rdy, .mem_addr,
        .mem_addr_ok_w, .mem_addr_ok_r, .mem_data_ok,
        .lookup_index, .lookup_tag, .hit, .victim_way, .victim_dirty, .victim_tag,
        .fill_en, .mark_dirty, .update_way, .victim_i, .victim_d, .touch,
        .word_sel, .way_sel, .line_we, .word_we, .from_fill, .wdata_out
    );

    l2_tag_store u_tag (
        .clk, .rstn, .lookup_index, .lookup_tag, .hit,
        .victim_way, .victim_dirty, .victim_tag,
        .fill_en, .mark_dirty, .update_way
    );

    l2_plru u_plru (
        .clk, .rstn, .lookup_index, .touch, .victim_i, .victim_d
    );

    l2_data_store u_data (
        .clk,
        .lookup_index,
        .word_sel,
        .way_sel,
        .line_we,
        .fill_line (mem_rline),
        .word_we,
        .wdata     (wdata_out),
        .from_fill,
        .rdata,
        .way_line  (mem_wline)
    );

endmodule

//--- src/l2_ctrl.sv
`timescale 1ns/1ps

module l2_ctrl (
    input  logic                        clk,
    input  logic                        rstn,
    // requesters
    input  logic                        i_req,
    input  logic [l2_pkg::ADDR_W-1:0]   i_addr,
    output logic                        i_addr_ok,
    output logic                        i_data_ok,
    input  logic                        d_req,
    input  logic                        d_we,
    input  logic [l2_pkg::ADDR_W-1:0]   d_addr,
    input  logic [l2_pkg::WORD_W-1:0]   d_wdata,
    output logic                        d_addr_ok,
    output logic                        d_data_ok,
    // memory
    output logic                        mem_req_w,
    output logic                        mem_req_r,
    output logic                        mem_rdy,
    output logic [l2_pkg::ADDR_W-1:0]   mem_addr,
    input  logic                        mem_addr_ok_w,
    input  logic                        mem_addr_ok_r,
    input  logic                        mem_data_ok,
    // tag store and plru
    output logic [l2_pkg::INDEX_W-1:0]  lookup_index,
    output logic [l2_pkg::TAG_W-1:0]    lookup_tag,
    input  logic [l2_pkg::WAYS-1:0]     hit,
    output logic [l2_pkg::WAY_W-1:0]    victim_way,
    input  logic                        victim_dirty,
    input  logic [l2_pkg::TAG_W-1:0]    victim_tag,
    output logic                        fill_en,
    output logic                        mark_dirty,
    output logic [l2_pkg::WAY_W-1:0]    update_way,
    input  logic                        victim_i,
    input  logic [l2_pkg::WAY_W-1:0]    victim_d,
    output logic [l2_pkg::WAYS-1:0]     touch,
    // data store
    output logic [l2_pkg::OFFSET_W-1:0] word_sel,
    output logic [l2_pkg::WAY_W-1:0]    way_sel,
    output logic                        line_we,
    output logic                        word_we,
    output logic                        from_fill,
    output logic [l2_pkg::WORD_W-1:0]   wdata_out
);

    localparam int LINE_LSB = l2_pkg::OFFSET_W + l2_pkg::BYTE_W;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, CHECK_DIRTY, WRITEBACK, REFILL_REQ, REFILL_WAIT, FILL_WRITE
    } state_t;

    state_t                     state_q, state_d;
    logic                       buf_d_q;
    logic                       buf_we_q;
    logic [l2_pkg::ADDR_W-1:0]  buf_addr_q;
    logic [l2_pkg::WORD_W-1:0]  buf_wdata_q;
    logic [l2_pkg::WAY_W-1:0]   fill_way_q;
    logic [l2_pkg::WAY_W-1:0]   hit_way;
    logic [l2_pkg::WAY_W-1:0]   victim_sel;
    logic                       take_d, take_i, fill_now;

    function automatic logic [l2_pkg::WAYS-1:0] onehot(input logic [l2_pkg::WAY_W-1:0] w);
        logic [l2_pkg::WAYS-1:0] v;
        v    = '0;
        v[w] = 1'b1;
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////////////////////////////////////////

    // data side wins when both ask
    assign take_d = (state_q == IDLE) && d_req;
    assign take_i = (state_q == IDLE) && i_req && !d_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q  <= IDLE;
            buf_d_q  <= 1'b0;
            buf_we_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_d || take_i) begin
                buf_d_q  <= take_d;
                buf_we_q <= take_d && d_we;
            end
        end
    end

    // fill_way_q holds the data victim for the word write after a fill
    always_ff @(posedge clk) begin
        if (take_d) begin
            buf_addr_q  <= d_addr;
            buf_wdata_q <= d_wdata;
        end else if (take_i) begin
            buf_addr_q <= i_addr;
        end
        if (fill_now) begin
            fill_way_q <= victim_d;
        end
    end

    assign lookup_tag   = buf_addr_q[l2_pkg::ADDR_W-1 -: l2_pkg::TAG_W];
    assign lookup_index = buf_addr_q[LINE_LSB +: l2_pkg::INDEX_W];
    assign word_sel     = buf_addr_q[l2_pkg::BYTE_W +: l2_pkg::OFFSET_W];
    assign wdata_out    = buf_wdata_q;

    ////////////////////////////////////////////////////////////////////////////
    // way choice
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < l2_pkg::WAYS; w++) begin
            if (hit[w]) begin
                hit_way = w[l2_pkg::WAY_W-1:0];
            end
        end
    end

    assign victim_sel = buf_d_q ? victim_d : {1'b0, victim_i};
    assign victim_way = victim_sel;

    // memory may hand back the line together with addr_ok_r
    assign fill_now = mem_data_ok &&
                      ((state_q == REFILL_WAIT) || (state_q == REFILL_REQ && mem_addr_ok_r));

    ////////////////////////////////////////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        i_addr_ok  = 1'b0;
        d_addr_ok  = 1'b0;
        i_data_ok  = 1'b0;
        d_data_ok  = 1'b0;
        mem_req_w  = 1'b0;
        mem_req_r  = 1'b0;
        mem_rdy    = 1'b0;
        mem_addr   = {buf_addr_q[l2_pkg::ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
        fill_en    = 1'b0;
        mark_dirty = 1'b0;
        update_way = victim_sel;
        touch      = '0;
        way_sel    = victim_sel;
        line_we    = 1'b0;
        word_we    = 1'b0;
        from_fill  = 1'b0;
        case (state_q)
            IDLE: begin
                d_addr_ok = 1'b1;
                i_addr_ok = i_req && !d_req;
                if (d_req || i_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                way_sel    = hit_way;
                update_way = hit_way;
                if (|hit) begin
                    touch   = hit;
                    state_d = IDLE;
                    if (buf_we_q) begin
                        word_we    = 1'b1;
                        mark_dirty = 1'b1;
                    end else begin
                        i_data_ok = !buf_d_q;
                        d_data_ok = buf_d_q;
                    end
                end else begin
                    state_d = CHECK_DIRTY;
                end
            end
            CHECK_DIRTY: begin
                state_d = victim_dirty ? WRITEBACK : REFILL_REQ;
            end
            WRITEBACK: begin
                mem_req_w = 1'b1;
                mem_addr  = {victim_tag, lookup_index, {LINE_LSB{1'b0}}};
                if (mem_addr_ok_w) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_r = 1'b1;
                if (mem_addr_ok_r) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                mem_rdy = 1'b1;
            end
            FILL_WRITE: begin
                way_sel    = fill_way_q;
                update_way = fill_way_q;
                word_we    = 1'b1;
                mark_dirty = 1'b1;
                touch      = onehot(fill_way_q);
                state_d    = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // install the arriving line in the victim way
        if (fill_now) begin
            line_we   = 1'b1;
            fill_en   = 1'b1;
            from_fill = 1'b1;
            if (buf_we_q) begin
                state_d = FILL_WRITE;
            end else begin
                touch     = onehot(victim_sel);
                i_data_ok = !buf_d_q;
                d_data_ok = buf_d_q;
                state_d   = IDLE;
            end
        end
    end

    a_mem_req_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_r && mem_req_w));

    a_data_ok_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(i_data_ok && d_data_ok));

endmodule

//--- src/l2_data_store.sv
`timescale 1ns/1ps

module l2_data_store (
    input  logic                        clk,
    input  logic [l2_pkg::INDEX_W-1:0]  lookup_index,
    input  logic [l2_pkg::OFFSET_W-1:0] word_sel,
    input  logic [l2_pkg::WAY_W-1:0]    way_sel,
    input  logic                        line_we,
    input  logic [l2_pkg::LINE_W-1:0]   fill_line,
    input  logic                        word_we,
    input  logic [l2_pkg::WORD_W-1:0]   wdata,
    input  logic                        from_fill,
    output logic [l2_pkg::WORD_W-1:0]   rdata,
    output logic [l2_pkg::LINE_W-1:0]   way_line
);

    logic [l2_pkg::LINE_W-1:0] line_mem [l2_pkg::WAYS][l2_pkg::SETS];
    logic [l2_pkg::LINE_W-1:0] src_line;

    // stored line also goes out as writeback data
    assign way_line = line_mem[way_sel][lookup_index];

    // a read miss returns straight from the memory line
    assign src_line = from_fill ? fill_line : way_line;
    assign rdata    = src_line[word_sel*l2_pkg::WORD_W +: l2_pkg::WORD_W];

    always_ff @(posedge clk) begin
        if (line_we) begin
            line_mem[way_sel][lookup_index] <= fill_line;
        end else if (word_we) begin
            line_mem[way_sel][lookup_index][word_sel*l2_pkg::WORD_W +: l2_pkg::WORD_W] <= wdata;
        end
    end

endmodule

//--- src/l2_pkg.sv
package l2_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;

    // 4 ways, instruction side fills only the lower two
    localparam int WAYS     = 4;
    localparam int I_WAYS   = 2;
    localparam int WAY_W    = 2;

    // 16 sets of 4 words each
    localparam int INDEX_W  = 4;
    localparam int SETS     = 1 << INDEX_W;
    localparam int OFFSET_W = 2;
    localparam int LINE_W   = WORD_W << OFFSET_W;

    ////////////////////////////////////////////////////////////////////////////
    // address split: tag | index | word offset | byte
    ////////////////////////////////////////////////////////////////////////////

    localparam int BYTE_W   = 2;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

endpackage

//--- src/l2_plru.sv
`timescale 1ns/1ps

module l2_plru (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [l2_pkg::INDEX_W-1:0] lookup_index,
    input  logic [l2_pkg::WAYS-1:0]    touch,
    output logic                       victim_i,
    output logic [l2_pkg::WAY_W-1:0]   victim_d
);

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    // each bit points at the side to evict next
    logic [2:0]                 tree_q [l2_pkg::SETS];
    logic [2:0]                 cur;
    logic [l2_pkg::WAY_W-1:0]   use_way;

    assign cur      = tree_q[lookup_index];
    assign victim_i = cur[1];
    assign victim_d = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_comb begin
        use_way = '0;
        for (int w = 0; w < l2_pkg::WAYS; w++) begin
            if (touch[w]) begin
                use_way = w[l2_pkg::WAY_W-1:0];
            end
        end
    end

    // point the path away from the touched way
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < l2_pkg::SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (|touch) begin
            tree_q[lookup_index][0] <= ~use_way[1];
            if (use_way[1]) begin
                tree_q[lookup_index][2] <= ~use_way[0];
            end else begin
                tree_q[lookup_index][1] <= ~use_way[0];
            end
        end
    end

    a_use_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(touch));

endmodule

//--- src/l2_tag_store.sv
`timescale 1ns/1ps

module l2_tag_store (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [l2_pkg::INDEX_W-1:0] lookup_index,
    input  logic [l2_pkg::TAG_W-1:0]   lookup_tag,
    output logic [l2_pkg::WAYS-1:0]    hit,
    input  logic [l2_pkg::WAY_W-1:0]   victim_way,
    output logic                       victim_dirty,
    output logic [l2_pkg::TAG_W-1:0]   victim_tag,
    input  logic                       fill_en,
    input  logic                       mark_dirty,
    input  logic [l2_pkg::WAY_W-1:0]   update_way
);

    logic [l2_pkg::TAG_W-1:0] tag_mem [l2_pkg::WAYS][l2_pkg::SETS];
    logic [l2_pkg::WAYS-1:0]  valid_q [l2_pkg::SETS];
    logic [l2_pkg::WAYS-1:0]  dirty_q [l2_pkg::SETS];

    // compare all ways of the set at once
    always_comb begin
        for (int w = 0; w < l2_pkg::WAYS; w++) begin
            hit[w] = valid_q[lookup_index][w] && (tag_mem[w][lookup_index] == lookup_tag);
        end
    end

    // victim readout for the writeback address
    assign victim_tag   = tag_mem[victim_way][lookup_index];
    assign victim_dirty = dirty_q[lookup_index][victim_way];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[update_way][lookup_index] <= lookup_tag;
        end
    end

    // fresh line is clean, a word write makes it dirty
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < l2_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[lookup_index][update_way] <= 1'b1;
            dirty_q[lookup_index][update_way] <= 1'b0;
        end else if (mark_dirty) begin
            dirty_q[lookup_index][update_way] <= 1'b1;
        end
    end

    // the controller never fills a line that is already present
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

//--- testbench/l2_checker.sv
`timescale 1ns/1ps

module l2_checker #(
    parameter logic [31:0] BASE  = 32'h0,
    parameter int          WORDS = 256
) (
    input  logic                      clk, rstn, report,
    input  logic                      i_req, i_addr_ok, i_data_ok,
    input  logic [l2_pkg::ADDR_W-1:0] i_addr,
    input  logic                      d_req, d_we, d_addr_ok, d_data_ok,
    input  logic [l2_pkg::ADDR_W-1:0] d_addr,
    input  logic [l2_pkg::WORD_W-1:0] d_wdata,
    input  logic [l2_pkg::WORD_W-1:0] rdata,
    input  logic                      mem_req_w, mem_req_r, mem_rdy, mem_addr_ok_w,
    input  logic [l2_pkg::ADDR_W-1:0] mem_addr,
    input  logic [l2_pkg::LINE_W-1:0] mem_wline,
    output int                        errors
);

    localparam int WPL = l2_pkg::LINE_W / l2_pkg::WORD_W;

    logic [l2_pkg::WORD_W-1:0] shadow [WORDS];
    logic [l2_pkg::WORD_W-1:0] exp_q [$];
    logic                      side_q [$];
    int                        value_errs, proto_errs, reads, wbacks;

    assign errors = value_errs + proto_errs;

    // same start content as the memory model
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - BASE) >> 2);
    endfunction

    task automatic value_fail(input string name, input logic [l2_pkg::LINE_W-1:0] exp,
                              input logic [l2_pkg::LINE_W-1:0] act);
        $display("FAIL t=%0t %s: expected %h, got %h", $time, name, exp, act);
        value_errs++;
    endtask

    task automatic proto_fail(input string what);
        $display("ERROR t=%0t %s", $time, what);
        proto_errs++;
    endtask

    initial begin
        for (int k = 0; k < WORDS; k++) begin
            shadow[k] = pattern_word(BASE + 32'(k * 4));
        end
        value_errs = 0;
        proto_errs = 0;
        reads      = 0;
        wbacks     = 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle checks sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [l2_pkg::LINE_W-1:0] line;
        if (!rstn) begin
            if (d_addr_ok !== 1'b1 || i_addr_ok !== 1'b0 || i_data_ok !== 1'b0 ||
                d_data_ok !== 1'b0 || mem_req_r !== 1'b0 || mem_req_w !== 1'b0 ||
                mem_rdy !== 1'b0) begin
                proto_fail("outputs are not at their idle values during reset");
            end
        end else begin
            if (d_req && i_addr_ok) begin
                proto_fail("i_addr_ok is high while d_req is high");
            end
            if (mem_req_r && mem_req_w) begin
                proto_fail("mem_req_r and mem_req_w are high together");
            end
            if ((mem_req_r || mem_req_w) && mem_addr[3:0] !== 4'h0) begin
                value_fail("mem_addr[3:0]", '0, mem_addr[3:0]);
            end
            // answers come back in acceptance order
            if (i_data_ok || d_data_ok) begin
                if (exp_q.size() == 0) begin
                    proto_fail("data_ok is high with no read outstanding");
                end else begin
                    if (side_q[0] !== d_data_ok) begin
                        proto_fail("data_ok came on the wrong requester side");
                    end
                    if (rdata !== exp_q[0]) begin
                        value_fail("rdata", exp_q[0], rdata);
                    end
                    void'(exp_q.pop_front());
                    void'(side_q.pop_front());
                    reads++;
                end
            end
            if (mem_req_w && mem_addr_ok_w) begin
                for (int k = 0; k < WPL; k++) begin
                    line[k*l2_pkg::WORD_W +: l2_pkg::WORD_W] = shadow[word_index(mem_addr) + k];
                end
                if (mem_wline !== line) begin
                    value_fail("mem_wline", line, mem_wline);
                end
                wbacks++;
            end
            if (i_req && i_addr_ok) begin
                exp_q.push_back(shadow[word_index(i_addr)]);
                side_q.push_back(1'b0);
            end
            if (d_req && d_addr_ok) begin
                if (d_we) begin
                    shadow[word_index(d_addr)] = d_wdata;
                end else begin
                    exp_q.push_back(shadow[word_index(d_addr)]);
                    side_q.push_back(1'b1);
                end
            end
        end
    end

    always @(posedge report) begin
        if (exp_q.size() != 0) begin
            proto_fail("reads were accepted but never answered");
        end
        $display("checker: %0d reads, %0d writebacks, %0d value errors, %0d protocol errors",
                 reads, wbacks, value_errs, proto_errs);
    end

endmodule

//--- testbench/tb_l2_cache.sv
`timescale 1ns/1ps

module tb_l2_cache;

    localparam int          CLK_PERIOD = 10;
    localparam int          N_OPS      = 400;
    localparam logic [15:0] SEED       = 16'd43361;
    // 64 lines over 16 sets, four tags compete per set
    localparam logic [31:0] WIN_BASE   = 32'h0003_0000;
    localparam int          WPL        = l2_pkg::LINE_W / l2_pkg::WORD_W;
    localparam int          WIN_WORDS  = 64 * WPL;
    // a dirty miss with slow memory is near 20 cycles
    localparam int          WATCHDOG   = (N_OPS * 40 + 100) * CLK_PERIOD;

    logic                      clk, rstn, report;
    logic                      i_req, i_addr_ok, i_data_ok;
    logic                      d_req, d_we, d_addr_ok, d_data_ok;
    logic [l2_pkg::ADDR_W-1:0] i_addr, d_addr, mem_addr, rd_addr;
    logic [l2_pkg::WORD_W-1:0] d_wdata, rdata;
    logic                      mem_req_w, mem_req_r, mem_rdy;
    logic                      mem_addr_ok_w, mem_addr_ok_r, mem_data_ok;
    logic [l2_pkg::LINE_W-1:0] mem_wline, mem_rline;
    logic [l2_pkg::WORD_W-1:0] mem_words [WIN_WORDS];
    logic [15:0]               lfsr_q;
    logic                      rd_pending, i_taken, d_taken;
    int                        delay, launched, accepted, errors;

    l2_cache u_l2_cache (.*);

    l2_checker #(.BASE(WIN_BASE), .WORDS(WIN_WORDS)) u_checker (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - WIN_BASE) >> 2);
    endfunction

    function automatic logic [31:0] rand_addr();
        logic [31:0] line_no;
        logic [31:0] word_no;
        line_no = take_bits(6);
        word_no = take_bits(2);
        return WIN_BASE + (line_no << 4) + (word_no << 2);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_line();
        for (int k = 0; k < WPL; k++) begin
            mem_rline[k*l2_pkg::WORD_W +: l2_pkg::WORD_W] = mem_words[word_index(rd_addr) + k];
        end
        mem_data_ok = 1'b1;
        rd_pending  = 1'b0;
        delay       = take_bits(2);
    endtask

    task automatic respond_memory();
        mem_addr_ok_w = 1'b0;
        mem_addr_ok_r = 1'b0;
        mem_data_ok   = 1'b0;
        if (mem_req_w) begin
            if (delay == 0) begin
                for (int k = 0; k < WPL; k++) begin
                    mem_words[word_index(mem_addr) + k] =
                        mem_wline[k*l2_pkg::WORD_W +: l2_pkg::WORD_W];
                end
                mem_addr_ok_w = 1'b1;
                delay         = take_bits(2);
            end else begin
                delay--;
            end
        end else if (mem_req_r && !rd_pending) begin
            if (delay == 0) begin
                mem_addr_ok_r = 1'b1;
                rd_pending    = 1'b1;
                rd_addr       = mem_addr;
                delay         = take_bits(2);
                // zero delay hands the line back with addr_ok
                if (delay == 0) begin
                    send_line();
                end
            end else begin
                delay--;
            end
        end else if (rd_pending && mem_rdy) begin
            if (delay == 0) begin
                send_line();
            end else begin
                delay--;
            end
        end
    endtask

    // a free requester asks half the time, a waiting one holds its request
    task automatic drive_requests();
        if (!i_req && launched < N_OPS && take_bits(1) != 0) begin
            i_req  = 1'b1;
            i_addr = rand_addr();
            launched++;
        end
        if (!d_req && launched < N_OPS && take_bits(1) != 0) begin
            d_req   = 1'b1;
            d_we    = take_bits(1);
            d_addr  = rand_addr();
            d_wdata = take_bits(32);
            launched++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        report        = 1'b0;
        i_req         = 1'b0;
        i_addr        = '0;
        d_req         = 1'b0;
        d_we          = 1'b0;
        d_addr        = '0;
        d_wdata       = '0;
        mem_addr_ok_w = 1'b0;
        mem_addr_ok_r = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rline     = '0;
        rd_pending    = 1'b0;
        rd_addr       = '0;
        i_taken       = 1'b0;
        d_taken       = 1'b0;
        launched      = 0;
        accepted      = 0;
        lfsr_q        = SEED;
        delay         = take_bits(2);
        for (int k = 0; k < WIN_WORDS; k++) begin
            mem_words[k] = pattern_word(WIN_BASE + 32'(k * 4));
        end
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        while (accepted < N_OPS) begin
            @(posedge clk);
            #1;
            if (i_taken) begin
                i_req = 1'b0;
            end
            if (d_taken) begin
                d_req = 1'b0;
            end
            respond_memory();
            drive_requests();
            @(negedge clk);
            i_taken  = i_req && i_addr_ok;
            d_taken  = d_req && d_addr_ok;
            accepted = accepted + int'(i_taken) + int'(d_taken);
        end
        // let the last request complete
        do begin
            @(posedge clk);
            #1;
            i_req = 1'b0;
            d_req = 1'b0;
            respond_memory();
            @(negedge clk);
        end while (!d_addr_ok);
        report = 1'b1;
        #1;
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: only %0d of %0d operations accepted by %0t", accepted, N_OPS, $time);
        report = 1'b1;
        #1;
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
src/l2_pkg.sv
src/l2_tag_store.sv
src/l2_plru.sv
src/l2_data_store.sv
src/l2_ctrl.sv
src/l2_cache.sv
testbench/l2_checker.sv
testbench/tb_l2_cache.sv
